// File: src.f
+incdir+sim
rtl/bus_pkg.sv
rtl/bus_arbiter.sv
rtl/bus_decoder.sv
rtl/mem_sram.sv
rtl/serial_tx_port.sv
rtl/clint_timer.sv
rtl/soc_bus.sv
sim/tb_soc_bus.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - rtl/bus_pkg.sv
  - rtl/bus_arbiter.sv
  - rtl/bus_decoder.sv
  - rtl/mem_sram.sv
  - rtl/serial_tx_port.sv
  - rtl/clint_timer.sv
  - rtl/soc_bus.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_soc_bus.sv

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// sram words that the random masters touch, all written once at the start
localparam int TOUCH_WORDS = 64;

// image of the sram, updated in accept order
logic [31:0] img [SRAM_WORDS];

// serial bytes still to come out, oldest first
logic [7:0]  serial_q [$];

// cycles since reset, same count as mtime
logic [63:0] cycle_cnt = '0;

// window of the last timer low-word read and the low word it returned
logic [63:0] lo_min  = '0;
logic [63:0] lo_max  = '0;
logic [31:0] lo_seen = '0;

// start pattern, every address bit takes part
function automatic logic [31:0] fill_word(input logic [31:0] addr);
  return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
endfunction

function automatic target_e target_of(input logic [31:0] addr);
  if (addr >= SRAM_BASE && addr < SRAM_BASE + 4 * SRAM_WORDS) begin
    return TGT_SRAM;
  end
  if (addr == SERIAL_ADDR) begin
    return TGT_SERIAL;
  end
  if (addr == CLINT_LO_ADDR || addr == CLINT_HI_ADDR) begin
    return TGT_CLINT;
  end
  return TGT_NONE;
endfunction

// byte lane update under the write strobes
function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                            input logic [3:0] wstrb);
  logic [31:0] res;
  res = old;
  for (int b = 0; b < 4; b++) begin
    if (wstrb[b]) begin
      res[b*8 +: 8] = wdata[b*8 +: 8];
    end
  end
  return res;
endfunction

`endif

// File: sim/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus import bus_pkg::*; ();

  localparam int          SRAM_WORDS   = 1024;
  localparam int          N_LSU        = 200;
  localparam int          N_IFU        = 200;
  localparam int          NUM_TXN      = 64 + N_LSU + N_IFU;
  localparam int          WATCHDOG_CYC = NUM_TXN * 64;
  localparam logic [31:0] SEED         = 32'h58db_f9b5;

  logic        clk;
  logic        reset_i;
  logic [31:0] ifu_addr_i;
  logic        ifu_valid_i;
  logic        ifu_ready_o;
  bus_resp_t   ifu_resp_o;
  logic        ifu_resp_valid_o;
  bus_req_t    lsu_req_i;
  logic        lsu_valid_i;
  logic        lsu_ready_o;
  bus_resp_t   lsu_resp_o;
  logic        lsu_resp_valid_o;
  logic [7:0]  serial_byte_o;
  logic        serial_strobe_o;

  integer lsu_seed;
  integer ifu_seed;
  logic   busy      = 1'b0;
  logic   owner_lsu = 1'b0;

  `include "tb_model.svh"

  soc_bus #(
    .SRAM_WORDS (SRAM_WORDS),
    .STALL_EN   (1'b1)
  ) uut (
    .clk              (clk),
    .reset_i          (reset_i),
    .ifu_addr_i       (ifu_addr_i),
    .ifu_valid_i      (ifu_valid_i),
    .ifu_ready_o      (ifu_ready_o),
    .ifu_resp_o       (ifu_resp_o),
    .ifu_resp_valid_o (ifu_resp_valid_o),
    .lsu_req_i        (lsu_req_i),
    .lsu_valid_i      (lsu_valid_i),
    .lsu_ready_o      (lsu_ready_o),
    .lsu_resp_o       (lsu_resp_o),
    .lsu_resp_valid_o (lsu_resp_valid_o),
    .serial_byte_o    (serial_byte_o),
    .serial_strobe_o  (serial_strobe_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset_i) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 64'd1;
    end
  end

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic fail_with(input string what);
    $display("%0t: %s", $time, what);
    abort_run();
  endtask

  task automatic check_resp(input string name, input bus_resp_t exp, input bus_resp_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected rdata %h resp %0d, actual rdata %h resp %0d",
               $time, name, exp.rdata, exp.resp, act.rdata, act.resp);
      abort_run();
    end
  endtask

  task automatic check_byte(input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("Error at %0t: serial_byte_o expected %h actual %h", $time, exp, act);
      abort_run();
    end
  endtask

  task automatic check_time(input logic [63:0] act, input logic [63:0] lo, input logic [63:0] hi);
    if (act < lo || act > hi) begin
      $display("Error at %0t: mtime expected %0d..%0d actual %0d", $time, lo, hi, act);
      abort_run();
    end
  endtask

  task automatic check_txn(input string port, input bus_req_t req, input bus_resp_t act,
                           input logic [63:0] acc_cnt, input int lat);
    bus_resp_t   exp;
    logic [31:0] idx;
    exp.rdata = '0;
    exp.resp  = RESP_OKAY;
    // everything but the sram answers in a fixed 2 cycles
    if (target_of(req.addr) != TGT_SRAM && lat != 2) begin
      $display("Error at %0t: %s latency expected 2 actual %0d", $time, port, lat);
      abort_run();
    end
    case (target_of(req.addr))
      TGT_SRAM: begin
        idx = (req.addr - SRAM_BASE) >> 2;
        if (!req.write) begin
          exp.rdata = img[idx];
        end
        check_resp(port, exp, act);
        if (req.write) begin
          img[idx] = merge_bytes(img[idx], req.wdata, req.wstrb);
        end
      end
      TGT_SERIAL: begin
        exp.resp = req.write ? RESP_OKAY : RESP_SLVERR;
        check_resp(port, exp, act);
      end
      TGT_CLINT: begin
        if (req.write) begin
          exp.resp = RESP_SLVERR;
          check_resp(port, exp, act);
        end else begin
          // data is checked against the time window instead
          exp.rdata = act.rdata;
          check_resp(port, exp, act);
          if (req.addr == CLINT_LO_ADDR) begin
            lo_min  = acc_cnt;
            lo_max  = cycle_cnt;
            lo_seen = act.rdata;
            check_time({lo_min[63:32], act.rdata}, lo_min, lo_max);
          end else begin
            check_time({act.rdata, lo_seen}, lo_min, lo_max);
          end
        end
      end
      default: begin
        exp.resp = RESP_DECERR;
        check_resp(port, exp, act);
      end
    endcase
  endtask

  task automatic draw_req(inout integer seed, output bus_req_t req);
    int unsigned kind;
    kind      = {$random(seed)} % 16;
    req.wdata = $random(seed);
    req.wstrb = $random(seed);
    req.write = $random(seed);
    if (kind < 9) begin
      req.addr = SRAM_BASE + 4 * ({$random(seed)} % TOUCH_WORDS);
    end else if (kind < 11) begin
      req.addr = SERIAL_ADDR;
    end else if (kind < 13) begin
      req.addr = CLINT_LO_ADDR;
    end else if (kind < 14) begin
      req.addr = CLINT_HI_ADDR;
    end else begin
      case ({$random(seed)} % 4)
        0:       req.addr = SRAM_BASE - 4;
        1:       req.addr = SRAM_BASE + 4 * SRAM_WORDS;
        2:       req.addr = 32'h0000_1000;
        default: req.addr = SERIAL_ADDR + 4;
      endcase
    end
  endtask

  // drives one request on one port and waits for its response strobe
  task automatic run_txn(input bit lsu, input bus_req_t req);
    logic [63:0] acc_cnt;
    int          lat;
    bus_resp_t   act;
    if (!lsu) begin
      req.wdata = '0;
      req.wstrb = '0;
      req.write = 1'b0;
    end
    @(posedge clk);
    #1;
    if (lsu) begin
      lsu_req_i   = req;
      lsu_valid_i = 1'b1;
    end else begin
      ifu_addr_i  = req.addr;
      ifu_valid_i = 1'b1;
    end
    do begin
      @(negedge clk);
    end while (!(lsu ? lsu_ready_o : ifu_ready_o));
    acc_cnt = cycle_cnt;
    if (req.write && req.addr == SERIAL_ADDR) begin
      serial_q.push_back(req.wdata[7:0]);
    end
    @(posedge clk);
    #1;
    if (lsu) begin
      lsu_valid_i = 1'b0;
    end else begin
      ifu_valid_i = 1'b0;
    end
    lat = 1;
    @(negedge clk);
    while (!(lsu ? lsu_resp_valid_o : ifu_resp_valid_o)) begin
      @(negedge clk);
      lat++;
    end
    act = lsu ? lsu_resp_o : ifu_resp_o;
    check_txn(lsu ? "lsu_resp_o" : "ifu_resp_o", req, act, acc_cnt, lat);
  endtask

  // grant order and one response strobe per accepted request
  always @(negedge clk) begin
    if (!reset_i) begin
      if (ifu_ready_o && lsu_ready_o) begin
        fail_with("both ready outputs are high");
      end
      if (busy && (ifu_ready_o || lsu_ready_o)) begin
        fail_with("a ready output rose while a transaction was outstanding");
      end
      if (!busy && ifu_valid_i && lsu_valid_i && !lsu_ready_o) begin
        fail_with("the load/store port was not accepted first");
      end
      if (!busy && (ifu_valid_i || lsu_valid_i) && !(ifu_ready_o || lsu_ready_o)) begin
        fail_with("the idle bus did not accept a valid request");
      end
      if (ifu_resp_valid_o || lsu_resp_valid_o) begin
        if (!busy || (ifu_resp_valid_o && lsu_resp_valid_o)
            || (lsu_resp_valid_o != owner_lsu)) begin
          fail_with("response strobe without a matching request on that port");
        end
        busy = 1'b0;
      end
      if (ifu_ready_o || lsu_ready_o) begin
        busy      = 1'b1;
        owner_lsu = lsu_ready_o;
      end
    end
  end

  always @(negedge clk) begin
    if (!reset_i && serial_strobe_o) begin
      if (serial_q.size() == 0) begin
        fail_with("serial strobe without an accepted serial write");
      end else begin
        check_byte(serial_q.pop_front(), serial_byte_o);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, the bus stopped answering", WATCHDOG_CYC);
    abort_run();
  end

  initial begin
    bus_req_t req;
    bus_req_t lreq;
    bus_req_t freq;
    reset_i     = 1'b1;
    ifu_addr_i  = '0;
    ifu_valid_i = 1'b0;
    lsu_req_i   = '0;
    lsu_valid_i = 1'b0;
    lsu_seed    = SEED;
    ifu_seed    = SEED ^ 32'h0f0f_0f0f;
    repeat (5) @(posedge clk);
    #1;
    reset_i = 1'b0;
    @(negedge clk);
    if (ifu_ready_o || lsu_ready_o || ifu_resp_valid_o || lsu_resp_valid_o
        || serial_strobe_o) begin
      fail_with("outputs are not idle after reset");
    end

    // known contents for every word the masters read
    for (int i = 0; i < TOUCH_WORDS; i++) begin
      req.addr  = SRAM_BASE + 4 * i;
      req.wdata = fill_word(req.addr);
      req.wstrb = 4'hf;
      req.write = 1'b1;
      run_txn(1'b1, req);
    end

    fork
      begin
        repeat (N_LSU) begin
          repeat ({$random(lsu_seed)} % 3) @(posedge clk);
          draw_req(lsu_seed, lreq);
          run_txn(1'b1, lreq);
        end
      end
      begin
        repeat (N_IFU) begin
          repeat ({$random(ifu_seed)} % 3) @(posedge clk);
          draw_req(ifu_seed, freq);
          run_txn(1'b0, freq);
        end
      end
    join

    repeat (4) @(negedge clk);
    if (serial_q.size() != 0) begin
      $display("%0d expected serial bytes never came out", serial_q.size());
      abort_run();
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// File: rtl/soc_bus.sv
`timescale 1ns/1ps

module soc_bus import bus_pkg::*; #(
  parameter int unsigned SRAM_WORDS = 1024,
  parameter bit          STALL_EN   = 1'b1
) (
  input  logic        clk,
  input  logic        reset_i,

  input  logic [31:0] ifu_addr_i,
  input  logic        ifu_valid_i,
  output logic        ifu_ready_o,
  output bus_resp_t   ifu_resp_o,
  output logic        ifu_resp_valid_o,

  input  bus_req_t    lsu_req_i,
  input  logic        lsu_valid_i,
  output logic        lsu_ready_o,
  output bus_resp_t   lsu_resp_o,
  output logic        lsu_resp_valid_o,

  output logic [7:0]  serial_byte_o,
  output logic        serial_strobe_o
);

  bus_req_t  arb_req;
  logic      arb_req_valid;
  bus_resp_t dec_resp;
  logic      dec_resp_valid;

  bus_req_t  tgt_req;
  logic      sram_valid;
  logic      serial_valid;
  logic      clint_valid;
  bus_resp_t sram_resp;
  logic      sram_resp_valid;
  bus_resp_t serial_resp;
  logic      serial_resp_valid;
  bus_resp_t clint_resp;
  logic      clint_resp_valid;

  bus_arbiter u_arbiter (
    .clk              (clk),
    .reset_i          (reset_i),
    .ifu_addr_i       (ifu_addr_i),
    .ifu_valid_i      (ifu_valid_i),
    .ifu_ready_o      (ifu_ready_o),
    .ifu_resp_o       (ifu_resp_o),
    .ifu_resp_valid_o (ifu_resp_valid_o),
    .lsu_req_i        (lsu_req_i),
    .lsu_valid_i      (lsu_valid_i),
    .lsu_ready_o      (lsu_ready_o),
    .lsu_resp_o       (lsu_resp_o),
    .lsu_resp_valid_o (lsu_resp_valid_o),
    .req_o            (arb_req),
    .req_valid_o      (arb_req_valid),
    .resp_i           (dec_resp),
    .resp_valid_i     (dec_resp_valid)
  );

  bus_decoder #(
    .SRAM_WORDS (SRAM_WORDS)
  ) u_decoder (
    .clk                 (clk),
    .reset_i             (reset_i),
    .req_i               (arb_req),
    .req_valid_i         (arb_req_valid),
    .resp_o              (dec_resp),
    .resp_valid_o        (dec_resp_valid),
    .sram_valid_o        (sram_valid),
    .serial_valid_o      (serial_valid),
    .clint_valid_o       (clint_valid),
    .tgt_req_o           (tgt_req),
    .sram_resp_i         (sram_resp),
    .sram_resp_valid_i   (sram_resp_valid),
    .serial_resp_i       (serial_resp),
    .serial_resp_valid_i (serial_resp_valid),
    .clint_resp_i        (clint_resp),
    .clint_resp_valid_i  (clint_resp_valid)
  );

  mem_sram #(
    .SRAM_WORDS (SRAM_WORDS),
    .STALL_EN   (STALL_EN)
  ) u_sram (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_i        (tgt_req),
    .req_valid_i  (sram_valid),
    .resp_o       (sram_resp),
    .resp_valid_o (sram_resp_valid)
  );

  serial_tx_port u_serial (
    .clk             (clk),
    .reset_i         (reset_i),
    .req_i           (tgt_req),
    .req_valid_i     (serial_valid),
    .resp_o          (serial_resp),
    .resp_valid_o    (serial_resp_valid),
    .serial_byte_o   (serial_byte_o),
    .serial_strobe_o (serial_strobe_o)
  );

  clint_timer u_clint (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_i        (tgt_req),
    .req_valid_i  (clint_valid),
    .resp_o       (clint_resp),
    .resp_valid_o (clint_resp_valid)
  );

endmodule

// File: rtl/clint_timer.sv
`timescale 1ns/1ps

module clint_timer import bus_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  bus_req_t  req_i,
  input  logic      req_valid_i,
  output bus_resp_t resp_o,
  output logic      resp_valid_o
);

  logic [63:0] mtime_q;
  logic [31:0] hi_latch_q;
  logic [31:0] rdata_q;
  resp_e       code_q;
  logic        resp_valid_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      mtime_q      <= 64'd0;
      hi_latch_q   <= 32'd0;
      resp_valid_q <= 1'b0;
    end else begin
      mtime_q      <= mtime_q + 64'd1;
      resp_valid_q <= req_valid_i;
      // snapshot upper half with the low word read
      if (req_valid_i && !req_i.write && req_i.addr == CLINT_LO_ADDR) begin
        hi_latch_q <= mtime_q[63:32];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      if (req_i.write) begin
        code_q  <= RESP_SLVERR;
        rdata_q <= 32'd0;
      end else begin
        code_q  <= RESP_OKAY;
        rdata_q <= (req_i.addr == CLINT_LO_ADDR) ? mtime_q[31:0] : hi_latch_q;
      end
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o.rdata = rdata_q;
  assign resp_o.resp  = code_q;

endmodule

// File: rtl/serial_tx_port.sv
`timescale 1ns/1ps

module serial_tx_port import bus_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  bus_req_t  req_i,
  input  logic      req_valid_i,
  output bus_resp_t resp_o,
  output logic      resp_valid_o,
  output logic [7:0] serial_byte_o,
  output logic      serial_strobe_o
);

  logic       resp_valid_q;
  resp_e      code_q;
  logic       strobe_q;
  logic [7:0] byte_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
      strobe_q     <= 1'b0;
    end else begin
      resp_valid_q <= req_valid_i;
      strobe_q     <= req_valid_i && req_i.write;
    end
  end

  // transmit side only, reads are rejected
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      code_q <= req_i.write ? RESP_OKAY : RESP_SLVERR;
      if (req_i.write) begin
        byte_q <= req_i.wdata[7:0];
      end
    end
  end

  assign resp_valid_o    = resp_valid_q;
  assign resp_o.rdata    = 32'd0;
  assign resp_o.resp     = code_q;
  assign serial_byte_o   = byte_q;
  assign serial_strobe_o = strobe_q;

endmodule

// File: rtl/mem_sram.sv
`timescale 1ns/1ps

module mem_sram import bus_pkg::*; #(
  parameter int unsigned SRAM_WORDS = 1024,
  parameter bit          STALL_EN   = 1'b1
) (
  input  logic      clk,
  input  logic      reset_i,
  input  bus_req_t  req_i,
  input  logic      req_valid_i,
  output bus_resp_t resp_o,
  output logic      resp_valid_o
);

  localparam int IDX_W = $clog2(SRAM_WORDS);

  logic [31:0]      mem_q [SRAM_WORDS];
  bus_req_t         pend_req_q;
  logic             pend_q;
  logic [19:0]      lfsr_q;
  logic             go;
  logic [31:0]      pend_off;
  logic [IDX_W-1:0] pend_idx;

  // x^20 + x^17 + 1
  always_ff @(posedge clk) begin
    if (reset_i) begin
      lfsr_q <= 20'd1;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
    end
  end

  assign go = STALL_EN ? lfsr_q[19] : 1'b1;

  assign pend_off = pend_req_q.addr - SRAM_BASE;
  assign pend_idx = pend_off[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pend_q <= 1'b0;
    end else if (req_valid_i) begin
      pend_q <= 1'b1;
    end else if (go) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      pend_req_q <= req_i;
    end
  end

  // write lands on the edge that ends the response cycle
  always_ff @(posedge clk) begin
    if (pend_q && go && pend_req_q.write) begin
      for (int b = 0; b < 4; b++) begin
        if (pend_req_q.wstrb[b]) begin
          mem_q[pend_idx][b*8 +: 8] <= pend_req_q.wdata[b*8 +: 8];
        end
      end
    end
  end

  assign resp_valid_o = pend_q && go;
  assign resp_o.rdata = pend_req_q.write ? 32'd0 : mem_q[pend_idx];
  assign resp_o.resp  = RESP_OKAY;

  // only one outstanding access on the bus
  a_no_overlap: assert property (
    @(posedge clk) disable iff (reset_i)
    req_valid_i |-> !pend_q
  );

endmodule

// File: rtl/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder import bus_pkg::*; #(
  parameter int unsigned SRAM_WORDS = 1024
) (
  input  logic      clk,
  input  logic      reset_i,

  input  bus_req_t  req_i,
  input  logic      req_valid_i,
  output bus_resp_t resp_o,
  output logic      resp_valid_o,

  output logic      sram_valid_o,
  output logic      serial_valid_o,
  output logic      clint_valid_o,
  output bus_req_t  tgt_req_o,

  input  bus_resp_t sram_resp_i,
  input  logic      sram_resp_valid_i,
  input  bus_resp_t serial_resp_i,
  input  logic      serial_resp_valid_i,
  input  bus_resp_t clint_resp_i,
  input  logic      clint_resp_valid_i
);

  localparam logic [31:0] SRAM_BYTES = 32'(SRAM_WORDS) << 2;
  localparam bus_resp_t DECERR_RESP = '{rdata: '0, resp: RESP_DECERR};
  localparam int RESP_W = $bits(bus_resp_t);

  target_e           tgt;
  logic [31:0]       sram_off;
  logic              decerr_valid_q;
  logic [RESP_W-1:0] merged;

  assign sram_off = req_i.addr - SRAM_BASE;

  always_comb begin
    if (sram_off < SRAM_BYTES) begin
      tgt = TGT_SRAM;
    end else if (req_i.addr == SERIAL_ADDR) begin
      tgt = TGT_SERIAL;
    end else if (req_i.addr == CLINT_LO_ADDR || req_i.addr == CLINT_HI_ADDR) begin
      tgt = TGT_CLINT;
    end else begin
      tgt = TGT_NONE;
    end
  end

  assign tgt_req_o      = req_i;
  assign sram_valid_o   = req_valid_i && (tgt == TGT_SRAM);
  assign serial_valid_o = req_valid_i && (tgt == TGT_SERIAL);
  assign clint_valid_o  = req_valid_i && (tgt == TGT_CLINT);

  // unmapped address, answered here one cycle later
  always_ff @(posedge clk) begin
    if (reset_i) begin
      decerr_valid_q <= 1'b0;
    end else begin
      decerr_valid_q <= req_valid_i && (tgt == TGT_NONE);
    end
  end

  // only one source is active, so an OR is enough
  always_comb begin
    merged = '0;
    if (sram_resp_valid_i) begin
      merged = merged | sram_resp_i;
    end
    if (serial_resp_valid_i) begin
      merged = merged | serial_resp_i;
    end
    if (clint_resp_valid_i) begin
      merged = merged | clint_resp_i;
    end
    if (decerr_valid_q) begin
      merged = merged | DECERR_RESP;
    end
  end

  assign resp_o       = bus_resp_t'(merged);
  assign resp_valid_o = sram_resp_valid_i || serial_resp_valid_i
                      || clint_resp_valid_i || decerr_valid_q;

  a_one_target_resp: assert property (
    @(posedge clk) disable iff (reset_i)
    $onehot0({sram_resp_valid_i, serial_resp_valid_i, clint_resp_valid_i, decerr_valid_q})
  );

endmodule

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,

  // read-only instruction fetch
  input  logic [31:0] ifu_addr_i,
  input  logic      ifu_valid_i,
  output logic      ifu_ready_o,
  output bus_resp_t ifu_resp_o,
  output logic      ifu_resp_valid_o,

  // load/store
  input  bus_req_t  lsu_req_i,
  input  logic      lsu_valid_i,
  output logic      lsu_ready_o,
  output bus_resp_t lsu_resp_o,
  output logic      lsu_resp_valid_o,

  // towards the decoder
  output bus_req_t  req_o,
  output logic      req_valid_o,
  input  bus_resp_t resp_i,
  input  logic      resp_valid_i
);

  grant_e   state_q;
  bus_req_t req_q;
  logic     req_valid_q;
  bus_req_t ifu_req;

  // fetch is always a full word read
  assign ifu_req = '{
    addr:  ifu_addr_i,
    wdata: '0,
    wstrb: '0,
    write: 1'b0
  };

  // lsu has fixed priority and nothing is accepted while a grant is held
  assign lsu_ready_o = (state_q == GNT_IDLE) && lsu_valid_i;
  assign ifu_ready_o = (state_q == GNT_IDLE) && ifu_valid_i && !lsu_valid_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q     <= GNT_IDLE;
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= 1'b0;
      case (state_q)
        GNT_IDLE: begin
          if (lsu_ready_o) begin
            state_q     <= GNT_LSU;
            req_valid_q <= 1'b1;
          end else if (ifu_ready_o) begin
            state_q     <= GNT_IFU;
            req_valid_q <= 1'b1;
          end
        end
        default: begin
          // grant released the cycle after the response
          if (resp_valid_i) begin
            state_q <= GNT_IDLE;
          end
        end
      endcase
    end
  end

  // latched request of the granted master
  always_ff @(posedge clk) begin
    if (lsu_ready_o) begin
      req_q <= lsu_req_i;
    end else if (ifu_ready_o) begin
      req_q <= ifu_req;
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;

  // data goes to both ports but the strobe only to the grant owner
  assign ifu_resp_o       = resp_i;
  assign lsu_resp_o       = resp_i;
  assign ifu_resp_valid_o = resp_valid_i && (state_q == GNT_IFU);
  assign lsu_resp_valid_o = resp_valid_i && (state_q == GNT_LSU);

  // a target answer without a pending grant would be lost
  a_resp_in_grant: assert property (
    @(posedge clk) disable iff (reset_i)
    resp_valid_i |-> (state_q != GNT_IDLE)
  );

endmodule

// File: rtl/bus_pkg.sv
package bus_pkg;

  // address map
  localparam logic [31:0] SRAM_BASE     = 32'h8000_0000;
  localparam logic [31:0] SERIAL_ADDR   = 32'ha000_03f8;
  localparam logic [31:0] CLINT_LO_ADDR = 32'ha000_0048;
  localparam logic [31:0] CLINT_HI_ADDR = 32'ha000_004c;

  // response codes, same values as AXI
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // arbiter state
  typedef enum logic [1:0] {
    GNT_IDLE,
    GNT_IFU,
    GNT_LSU
  } grant_e;

  // decoder target select
  typedef enum logic [1:0] {
    TGT_SRAM,
    TGT_SERIAL,
    TGT_CLINT,
    TGT_NONE
  } target_e;

  // one single-beat request
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        write;
  } bus_req_t;

  // one response
  typedef struct packed {
    logic [31:0] rdata;
    resp_e       resp;
  } bus_resp_t;

endpackage
